// ==== src/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

    parameter int dataWidth    = 32;
    parameter int regAddrWidth = 5;

    typedef logic [dataWidth-1:0]    word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;
    typedef logic [15:0]             imm_t;   // I-type immediate field
    typedef logic [4:0]              shamt_t; // Shift amount field, also picks seb/seh

    typedef enum logic [5:0] {
        OpSpecial  = 6'b000000, // R-type, selected by funct
        OpSpecial2 = 6'b011100, // mul
        OpSpecial3 = 6'b011111, // seb, seh
        OpAddi     = 6'b001000,
        OpAddiu    = 6'b001001,
        OpSlti     = 6'b001010,
        OpSltiu    = 6'b001011,
        OpAndi     = 6'b001100,
        OpOri      = 6'b001101,
        OpXori     = 6'b001110,
        OpIdle     = 6'b111111  // Decoder state out of reset
    } opCodeE;

    typedef enum logic [5:0] {
        FnMul  = 6'b000010,
        FnAdd  = 6'b100000,
        FnAddu = 6'b100001,
        FnSub  = 6'b100010,
        FnSubu = 6'b100011,
        FnAnd  = 6'b100100,
        FnOr   = 6'b100101,
        FnXor  = 6'b100110,
        FnSlt  = 6'b101010,
        FnSltu = 6'b101011
    } functE;

    // SPECIAL3 BSHFL funct, same code as add
    localparam functE FnBshfl = functE'(6'b100000);

    localparam shamt_t ShSeb = 5'b10000;
    localparam shamt_t ShSeh = 5'b11000;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluSltu,
        AluMul, AluSeb, AluSeh, AluNop
    } aluOpE;

endpackage

`default_nettype wire

// ==== src/ctrlBus.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decoded control bundle, decoder to datapath
interface ctrlBus;
    import mipsPkg::*;

    logic  RegDst;   // rd rather than rt as destination
    logic  RegWrite;
    logic  AluSrc;   // Extended immediate rather than rt
    logic  SignExt;
    aluOpE AluOp;
    logic  Illegal;

    modport decoder (
        output RegDst, RegWrite, AluSrc, SignExt, AluOp, Illegal
    );

    modport datapath (
        input RegDst, RegWrite, AluSrc, SignExt, AluOp, Illegal
    );

endinterface

`default_nettype wire

// ==== src/controlDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
    input  wire              Clk,
    input  wire              Rst,
    input  mipsPkg::opCodeE  OpCode,
    input  mipsPkg::functE   Funct,
    input  mipsPkg::shamt_t  Shamt,
    input  wire              Load,
    ctrlBus.decoder          ctrl
);
    import mipsPkg::*;

    opCodeE opState;

    ////////////////////////////////////////
    // Opcode state register
    ////////////////////////////////////////
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst)
            opState <= OpIdle;
        else if (Load)
            opState <= OpCode;
    end

    ////////////////////////////////////////
    // Control outputs per state
    ////////////////////////////////////////
    always_comb begin
        ctrl.RegDst   = 1'b0;
        ctrl.RegWrite = 1'b0;
        ctrl.AluSrc   = 1'b0;
        ctrl.SignExt  = 1'b0;
        ctrl.AluOp    = AluNop;
        ctrl.Illegal  = 1'b0;

        case (opState)
            OpIdle: ; // Nothing in flight
            OpSpecial: begin
                ctrl.RegDst   = 1'b1;
                ctrl.RegWrite = 1'b1;
                case (Funct)
                    FnAdd, FnAddu: ctrl.AluOp = AluAdd; // No overflow trap
                    FnSub, FnSubu: ctrl.AluOp = AluSub;
                    FnAnd:         ctrl.AluOp = AluAnd;
                    FnOr:          ctrl.AluOp = AluOr;
                    FnXor:         ctrl.AluOp = AluXor;
                    FnSlt:         ctrl.AluOp = AluSlt;
                    FnSltu:        ctrl.AluOp = AluSltu;
                    default: begin
                        ctrl.RegWrite = 1'b0;
                        ctrl.Illegal  = 1'b1;
                    end
                endcase
            end
            OpSpecial2: begin
                ctrl.RegDst   = 1'b1;
                ctrl.RegWrite = (Funct == FnMul);
                ctrl.AluOp    = (Funct == FnMul) ? AluMul : AluNop;
                ctrl.Illegal  = (Funct != FnMul);
            end
            OpSpecial3: begin
                ctrl.RegDst = 1'b1;
                if (Funct == FnBshfl && Shamt == ShSeb) begin
                    ctrl.RegWrite = 1'b1;
                    ctrl.AluOp    = AluSeb;
                end else if (Funct == FnBshfl && Shamt == ShSeh) begin
                    ctrl.RegWrite = 1'b1;
                    ctrl.AluOp    = AluSeh;
                end else begin
                    ctrl.Illegal  = 1'b1;
                end
            end
            OpAddi, OpAddiu: begin
                ctrl.RegWrite = 1'b1;
                ctrl.AluSrc   = 1'b1;
                ctrl.SignExt  = 1'b1;
                ctrl.AluOp    = AluAdd;
            end
            OpSlti, OpSltiu: begin
                ctrl.RegWrite = 1'b1;
                ctrl.AluSrc   = 1'b1;
                ctrl.SignExt  = 1'b1;  // Sign extended even for sltiu
                ctrl.AluOp    = (opState == OpSlti) ? AluSlt : AluSltu;
            end
            OpAndi, OpOri, OpXori: begin
                ctrl.RegWrite = 1'b1;
                ctrl.AluSrc   = 1'b1;  // Logical immediates zero extend
                ctrl.AluOp    = (opState == OpAndi) ? AluAnd :
                                (opState == OpOri)  ? AluOr  : AluXor;
            end
            default: ctrl.Illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/instrQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrQueue #(
    parameter int QueueDepth = 4
) (
    input  wire             Clk,
    input  wire             Rst,
    input  wire             InValid,
    input  mipsPkg::word_t  InInstr,
    output logic            InCredit,
    output logic            QValid,
    output mipsPkg::word_t  QInstr,
    input  wire             QPop
);
    import mipsPkg::*;

    localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CntW = $clog2(QueueDepth + 1);

    word_t           mem [QueueDepth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            full;
    logic            push;
    logic            pop;

    assign full     = (count == CntW'(QueueDepth));
    assign push     = InValid && !full;
    assign pop      = QPop && QValid;
    assign QValid   = (count != '0);
    assign QInstr   = mem[rdPtr];
    assign InCredit = pop;  // Slot freed this cycle goes straight back

    always_ff @(posedge Clk) begin
        if (push)
            mem[wrPtr] <= InInstr;
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push)
                wrPtr <= (wrPtr == PtrW'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
            if (pop)
                rdPtr <= (rdPtr == PtrW'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // Producer credits must keep it off a full queue
    assert property (@(posedge Clk) disable iff (Rst)
        !(InValid && full) && !(QPop && !QValid));

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire               Clk,
    input  wire               Rst,
    input  mipsPkg::regAddr_t RdAddrA,
    input  mipsPkg::regAddr_t RdAddrB,
    output mipsPkg::word_t    RdDataA,
    output mipsPkg::word_t    RdDataB,
    input  wire               WrEn,
    input  mipsPkg::regAddr_t WrAddr,
    input  mipsPkg::word_t    WrData
);
    import mipsPkg::*;

    localparam int NumRegs = 2 ** regAddrWidth;

    word_t regs [NumRegs];

    assign RdDataA = regs[RdAddrA];
    assign RdDataB = regs[RdAddrB];

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            for (int i = 0; i < NumRegs; i++)
                regs[i] <= '0;
        end else if (WrEn && WrAddr != '0) begin // r0 stays zero
            regs[WrAddr] <= WrData;
        end
    end

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  mipsPkg::aluOpE Op,
    input  mipsPkg::word_t A,
    input  mipsPkg::word_t B,
    output mipsPkg::word_t Y
);
    import mipsPkg::*;

    word_t sum;
    word_t diff;
    word_t prod;
    logic  ltSigned;
    logic  ltUnsigned;

    assign sum        = A + B;
    assign diff       = A - B;
    assign prod       = A * B;  // Low word of the product only
    assign ltSigned   = $signed(A) < $signed(B);
    assign ltUnsigned = A < B;

    ////////////////////////////////////////
    // Result select
    ////////////////////////////////////////
    always_comb begin
        case (Op)
            AluAdd:  Y = sum;
            AluSub:  Y = diff;
            AluAnd:  Y = A & B;
            AluOr:   Y = A | B;
            AluXor:  Y = A ^ B;
            AluSlt:  Y = word_t'(ltSigned);
            AluSltu: Y = word_t'(ltUnsigned);
            AluMul:  Y = prod;

            // seb and seh only look at rt, which arrives on B
            AluSeb: begin
                Y = {{(dataWidth-8){B[7]}}, B[7:0]};
            end
            AluSeh: begin
                Y = {{(dataWidth-16){B[15]}}, B[15:0]};
            end

            AluNop:  Y = '0;
            default: Y = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/executeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeUnit #(
    parameter int MulCycles = 3
) (
    input  wire               Clk,
    input  wire               Rst,
    input  wire               QValid,
    input  mipsPkg::word_t    QInstr,
    output logic              QPop,
    output logic              WbValid,
    output mipsPkg::regAddr_t WbReg,
    output mipsPkg::word_t    WbData,
    output logic              IllegalOp
);
    import mipsPkg::*;

    localparam int CntW = $clog2(MulCycles + 1);

    logic [25:0]     instrReg;  // Stage one payload below the opcode
    logic            s1Valid;
    logic [CntW-1:0] mulCnt;
    logic            isMul;
    logic            done;      // Instruction finishes this cycle
    regAddr_t        rs;
    regAddr_t        rt;
    regAddr_t        rd;
    imm_t            imm;
    word_t           extImm;
    word_t           rdDataA;
    word_t           rdDataB;
    word_t           operandB;

    ctrlBus ctrl ();

    ////////////////////////////////////////
    // Stage one
    ////////////////////////////////////////
    assign QPop = QValid && (!s1Valid || done);

    always_ff @(posedge Clk) begin
        if (QPop)
            instrReg <= QInstr[25:0];
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst)
            s1Valid <= 1'b0;
        else if (QPop)
            s1Valid <= 1'b1;
        else if (done)
            s1Valid <= 1'b0;
    end

    controlDecoder decoder0 (
        .Clk    (Clk),
        .Rst    (Rst),
        .OpCode (opCodeE'(QInstr[31:26])), // Loaded together with instrReg
        .Funct  (functE'(instrReg[5:0])),
        .Shamt  (instrReg[10:6]),
        .Load   (QPop),
        .ctrl   (ctrl)
    );

    ////////////////////////////////////////
    // Stage two
    ////////////////////////////////////////
    assign rs     = instrReg[25:21];
    assign rt     = instrReg[20:16];
    assign rd     = instrReg[15:11];
    assign imm    = instrReg[15:0];
    assign extImm = ctrl.SignExt ? {{(dataWidth-16){imm[15]}}, imm}
                                 : {{(dataWidth-16){1'b0}}, imm};
    assign operandB = ctrl.AluSrc ? extImm : rdDataB;

    // Multiply holds stage two for MulCycles cycles
    assign isMul = (ctrl.AluOp == AluMul);
    assign done  = s1Valid && (!isMul || mulCnt == CntW'(MulCycles - 1));

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst)
            mulCnt <= '0;
        else if (s1Valid && isMul)
            mulCnt <= done ? '0 : mulCnt + 1'b1;
    end

    regFile regFile0 (
        .Clk     (Clk),
        .Rst     (Rst),
        .RdAddrA (rs),
        .RdAddrB (rt),
        .RdDataA (rdDataA),
        .RdDataB (rdDataB),
        .WrEn    (WbValid),  // Lands at the edge closing the WbValid cycle
        .WrAddr  (WbReg),
        .WrData  (WbData)
    );

    alu alu0 (
        .Op (ctrl.AluOp),
        .A  (rdDataA),
        .B  (operandB),
        .Y  (WbData)
    );

    assign WbReg     = ctrl.RegDst ? rd : rt;
    assign WbValid   = done && ctrl.RegWrite;
    assign IllegalOp = s1Valid && ctrl.Illegal;

    assert property (@(posedge Clk) disable iff (Rst) !(WbValid && IllegalOp));

endmodule

`default_nettype wire

// ==== src/mipsCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
    parameter int QueueDepth = 4,
    parameter int MulCycles  = 3
) (
    input  wire               Clk,
    input  wire               Rst,
    input  wire               InValid,
    input  mipsPkg::word_t    InInstr,
    output logic              InCredit,
    output logic              WbValid,
    output mipsPkg::regAddr_t WbReg,
    output mipsPkg::word_t    WbData,
    output logic              IllegalOp
);
    import mipsPkg::*;

    // Queue to execute link
    logic  qValid;
    word_t qInstr;
    logic  qPop;

    instrQueue #(
        .QueueDepth (QueueDepth)
    ) queue0 (
        .Clk      (Clk),
        .Rst      (Rst),
        .InValid  (InValid),
        .InInstr  (InInstr),
        .InCredit (InCredit),
        .QValid   (qValid),
        .QInstr   (qInstr),
        .QPop     (qPop)
    );

    executeUnit #(
        .MulCycles (MulCycles)
    ) exec0 (
        .Clk       (Clk),
        .Rst       (Rst),
        .QValid    (qValid),
        .QInstr    (qInstr),
        .QPop      (qPop),
        .WbValid   (WbValid),
        .WbReg     (WbReg),
        .WbData    (WbData),
        .IllegalOp (IllegalOp)
    );

endmodule

`default_nettype wire

// ==== testbench/mipsCoreModel.svh ====
`ifndef MIPS_CORE_MODEL_SVH
`define MIPS_CORE_MODEL_SVH

    // Architectural registers as the model sees them
    word_t modelRegs [32];

    function automatic void modelReset();
        for (int i = 0; i < 32; i++)
            modelRegs[i] = '0;
    endfunction

    ////////////////////////////////////////
    // Instruction semantics
    ////////////////////////////////////////
    function automatic void modelIssue(input word_t instr, input int idx);
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t dest;
        word_t    a;
        word_t    b;
        word_t    sImm;
        word_t    zImm;
        word_t    res;
        bit       bad;
        rs   = instr[25:21];
        rt   = instr[20:16];
        dest = instr[15:11];   // rd for the register forms
        a    = modelRegs[rs];
        b    = modelRegs[rt];
        sImm = {{16{instr[15]}}, instr[15:0]};
        zImm = {16'h0000, instr[15:0]};
        res  = '0;
        bad  = 1'b0;
        if (instr[31:29] == 3'b001)
            dest = rt;         // I-type codes all start with 001
        case (instr[31:26])
            OpSpecial: begin
                case (instr[5:0])
                    FnAdd, FnAddu: res = a + b;
                    FnSub, FnSubu: res = a - b;
                    FnAnd:         res = a & b;
                    FnOr:          res = a | b;
                    FnXor:         res = a ^ b;
                    FnSlt:         res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FnSltu:        res = (a < b) ? 32'd1 : 32'd0;
                    default:       bad = 1'b1;
                endcase
            end
            OpSpecial2: begin
                if (instr[5:0] == FnMul)
                    res = a * b;   // Low word only
                else
                    bad = 1'b1;
            end
            OpSpecial3: begin
                if (instr[5:0] != FnBshfl)
                    bad = 1'b1;
                else if (instr[10:6] == ShSeb)
                    res = {{24{b[7]}}, b[7:0]};
                else if (instr[10:6] == ShSeh)
                    res = {{16{b[15]}}, b[15:0]};
                else
                    bad = 1'b1;
            end
            OpAddi, OpAddiu: res = a + sImm;
            OpSlti:          res = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
            OpSltiu:         res = (a < sImm) ? 32'd1 : 32'd0; // Unsigned compare of sign-extended imm
            OpAndi:          res = a & zImm;
            OpOri:           res = a | zImm;
            OpXori:          res = a ^ zImm;
            default:         bad = 1'b1;
        endcase
        expName.push_back($sformatf("instr %0d (%h)", idx, instr));
        expIllegal.push_back(bad);
        expReg.push_back(dest);
        expData.push_back(res);
        if (!bad && dest != '0)
            modelRegs[dest] = res;   // r0 keeps reading zero
    endfunction

    ////////////////////////////////////////
    // Random stimulus
    ////////////////////////////////////////
    function automatic regAddr_t randReg();
        if ($urandom_range(0, 7) == 0)
            return regAddr_t'($urandom_range(0, 31));
        return regAddr_t'($urandom_range(0, 7));  // Small set so results feed later instructions
    endfunction

    function automatic word_t encodeR(input logic [5:0] op, input regAddr_t rs,
                                      input regAddr_t rt, input regAddr_t rd,
                                      input shamt_t sh, input logic [5:0] fn);
        return {op, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t encodeI(input logic [5:0] op, input regAddr_t rs,
                                      input regAddr_t rt, input imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t randomInstr();
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        imm_t     imm;
        rs  = randReg();
        rt  = randReg();
        rd  = randReg();
        imm = imm_t'($urandom);
        case ($urandom_range(0, 24))
            0:       return encodeR(OpSpecial, rs, rt, rd, 5'd0, FnAdd);
            1:       return encodeR(OpSpecial, rs, rt, rd, 5'd0, FnAddu);
            2:       return encodeR(OpSpecial, rs, rt, rd, 5'd0, FnSub);
            3:       return encodeR(OpSpecial, rs, rt, rd, 5'd0, FnSubu);
            4:       return encodeR(OpSpecial, rs, rt, rd, 5'd0, FnAnd);
            5:       return encodeR(OpSpecial, rs, rt, rd, 5'd0, FnOr);
            6:       return encodeR(OpSpecial, rs, rt, rd, 5'd0, FnXor);
            7:       return encodeR(OpSpecial, rs, rt, rd, 5'd0, FnSlt);
            8:       return encodeR(OpSpecial, rs, rt, rd, 5'd0, FnSltu);
            9, 10:   return encodeR(OpSpecial2, rs, rt, rd, 5'd0, FnMul);
            11:      return encodeR(OpSpecial3, 5'd0, rt, rd, ShSeb, FnBshfl);
            12:      return encodeR(OpSpecial3, 5'd0, rt, rd, ShSeh, FnBshfl);
            13:      return encodeI(OpAddi, rs, rt, imm);
            14:      return encodeI(OpAddiu, rs, rt, imm);
            15:      return encodeI(OpAndi, rs, rt, imm);
            16:      return encodeI(OpOri, rs, rt, imm);
            17:      return encodeI(OpXori, rs, rt, imm);
            18:      return encodeI(OpSlti, rs, rt, imm);
            19:      return encodeI(OpSltiu, rs, rt, imm);
            // Codes outside the supported set
            20:      return encodeR(OpSpecial, rs, rt, rd, 5'd0, 6'b000000);    // sll
            21:      return encodeR(OpSpecial2, rs, rt, rd, 5'd0, 6'b000000);   // madd
            22:      return encodeR(OpSpecial3, 5'd0, rt, rd, 5'b00010, FnBshfl); // wsbh
            23:      return encodeI(6'b100011, rs, rt, imm);                   // lw
            default: return encodeI(6'b000100, rs, rt, imm);                  // beq
        endcase
    endfunction

    function automatic int pickGap();
        if ($urandom_range(0, 1) == 0)
            return 0;
        return int'($urandom_range(1, 3));
    endfunction

`endif

// ==== testbench/mipsCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;
    import mipsPkg::*;

    localparam int QueueDepth  = 4;
    localparam int MulCycles   = 3;
    localparam int numInstr    = 500;
    localparam int resetCycles = 8;

    logic     Clk;
    logic     Rst;
    logic     InValid;
    word_t    InInstr;
    logic     InCredit;
    logic     WbValid;
    regAddr_t WbReg;
    word_t    WbData;
    logic     IllegalOp;

    int credits;   // Free queue slots as the producer counts them
    int issued;
    int gap;       // Idle cycles left before the next send

    // Expected results in program order
    string    expName [$];
    bit       expIllegal [$];
    regAddr_t expReg [$];
    word_t    expData [$];

    `include "mipsCoreModel.svh"

    mipsCore #(
        .QueueDepth (QueueDepth),
        .MulCycles  (MulCycles)
    ) dut0 (
        .Clk       (Clk),
        .Rst       (Rst),
        .InValid   (InValid),
        .InInstr   (InInstr),
        .InCredit  (InCredit),
        .WbValid   (WbValid),
        .WbReg     (WbReg),
        .WbData    (WbData),
        .IllegalOp (IllegalOp)
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    initial begin
        repeat (resetCycles + numInstr * (MulCycles + 4)) @(posedge Clk);
        abortRun("The run timed out before every instruction finished");
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic checkWb(input string name, input regAddr_t expR, input word_t expD);
        if (WbValid !== 1'b1 || IllegalOp !== 1'b0 || WbReg !== expR || WbData !== expD) begin
            abortRun($sformatf("** Error %s: expected r%0d = %h, actual r%0d = %h (wb %b ill %b)",
                               name, expR, expD, WbReg, WbData, WbValid, IllegalOp));
        end
    endtask

    task automatic checkIllegal(input string name);
        if (IllegalOp !== 1'b1 || WbValid !== 1'b0) begin
            abortRun($sformatf("** Error %s: expected IllegalOp 1 WbValid 0, actual %b %b",
                               name, IllegalOp, WbValid));
        end
    endtask

    // Sampled mid-cycle where the outputs are settled
    task automatic scoreOutputs();
        if (InCredit)
            credits++;
        if (credits > QueueDepth) begin
            abortRun($sformatf("The producer holds %0d credits for a queue of %0d entries",
                               credits, QueueDepth));
        end else if (WbValid || IllegalOp) begin
            if (expName.size() == 0) begin
                abortRun("The DUT reported a result while no instruction was outstanding");
            end else begin
                if (expIllegal[0])
                    checkIllegal(expName[0]);
                else
                    checkWb(expName[0], expReg[0], expData[0]);
                expName.delete(0);
                expIllegal.delete(0);
                expReg.delete(0);
                expData.delete(0);
            end
        end
    endtask

    ////////////////////////////////////////
    // Producer
    ////////////////////////////////////////
    task automatic driveProducer();
        word_t instr;
        if (issued < numInstr && gap == 0 && credits > 0) begin
            instr = randomInstr();
            modelIssue(instr, issued);
            InValid <= 1'b1;
            InInstr <= instr;
            credits--;   // One credit per valid cycle
            issued++;
            gap = pickGap();
        end else begin
            InValid <= 1'b0;
            if (gap > 0)
                gap--;
        end
    endtask

    initial begin
        void'($urandom(32'hda));
        Rst     = 1'b1;
        InValid = 1'b0;
        InInstr = '0;
        credits = QueueDepth;
        issued  = 0;
        gap     = 0;
        modelReset();
        repeat (resetCycles) @(posedge Clk);
        Rst <= 1'b0;
        while (issued < numInstr || expName.size() != 0) begin
            @(negedge Clk);
            scoreOutputs();
            @(posedge Clk);
            driveProducer();
        end
        if (credits == QueueDepth && expName.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            abortRun($sformatf("The producer ends with %0d credits instead of %0d",
                               credits, QueueDepth));
        end
    end

endmodule

`default_nettype wire

// ==== mipsCore.f ====
+incdir+testbench
src/mipsPkg.sv
src/ctrlBus.sv
src/controlDecoder.sv
src/instrQueue.sv
src/regFile.sv
src/alu.sv
src/executeUnit.sv
src/mipsCore.sv
testbench/mipsCoreTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= mipsCoreTb
RTL_TOP    ?= mipsCore
FILELIST   ?= mipsCore.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(wildcard src/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
